// File: isa_pkg.sv
/* Integer ISA definitions for the RV64I execute stage:
   register width, register numbers and the ALU and branch operation codes */

package isa_pkg;

    parameter int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      regno_t;

    // Register-register and immediate forms share one code; use_imm picks the operand
    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_sll   = 4'd2,
        alu_slt   = 4'd3,
        alu_sltu  = 4'd4,
        alu_xor   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_or    = 4'd8,
        alu_and   = 4'd9,
        alu_lui   = 4'd10,
        alu_auipc = 4'd11
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_beq  = 4'd1,
        br_bne  = 4'd2,
        br_blt  = 4'd3,
        br_bge  = 4'd4,
        br_bltu = 4'd5,
        br_bgeu = 4'd6,
        br_jal  = 4'd7,
        br_jalr = 4'd8
    } br_op_e;

endpackage

// File: pipe_pkg.sv
/* Pipeline payloads: the decoded request into execute, the forwarding
   view of a later stage and the registered execute result */

package pipe_pkg;

    // Decoded instruction as handed over by decode
    typedef struct packed {
        isa_pkg::xlen_t   pc;
        isa_pkg::xlen_t   rs1_val;
        isa_pkg::xlen_t   rs2_val;
        isa_pkg::xlen_t   imm;
        isa_pkg::regno_t  rs1;
        isa_pkg::regno_t  rs2;
        isa_pkg::regno_t  rd;
        isa_pkg::alu_op_e alu_op;
        isa_pkg::br_op_e  br_op;
        logic             use_imm;
        logic             is_load;
        logic             is_store;
        logic             writes_rd;
    } ex_req_t;

    // For the memory stage value already holds load data when is_load is set
    typedef struct packed {
        isa_pkg::regno_t rd;
        logic            writes_rd;
        logic            is_load;
        isa_pkg::xlen_t  value;
    } fwd_src_t;

    typedef struct packed {
        isa_pkg::xlen_t  result;
        isa_pkg::xlen_t  store_data;
        isa_pkg::regno_t rd;
        logic            writes_rd;
        logic            is_load;
        logic            is_store;
        logic            branch_taken;
        isa_pkg::xlen_t  target;
    } ex_rsp_t;

endpackage

// File: operand_forward.sv
/* Operand forwarding for execute: picks rs1 and rs2 from the register file
   or a later stage, and flags a load-use hazard against the ALU stage */
`timescale 1ns/1ps

module operand_forward (
    input  pipe_pkg::ex_req_t  req,
    input  pipe_pkg::fwd_src_t fwd_alu,
    input  pipe_pkg::fwd_src_t fwd_mem,
    input  pipe_pkg::fwd_src_t fwd_wb,
    output isa_pkg::xlen_t     op_a,
    output isa_pkg::xlen_t     op_b,
    output logic               hazard
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // Youngest producer wins, x0 always reads zero
    function automatic xlen_t pick_operand(
        input regno_t   rs,
        input xlen_t    rf_value,
        input fwd_src_t alu,
        input fwd_src_t mem,
        input fwd_src_t wb
    );
        xlen_t value;
        if (rs == '0)
            value = '0;
        else if (alu.writes_rd && !alu.is_load && alu.rd == rs)
            value = alu.value;
        else if (mem.writes_rd && mem.rd == rs)
            value = mem.value;
        else if (wb.writes_rd && wb.rd == rs)
            value = wb.value;
        else
            value = rf_value;
        return value;
    endfunction

    // Load data is not ready until the load sits in the memory stage
    function automatic logic load_in_alu(
        input regno_t   rs,
        input fwd_src_t alu
    );
        return (rs != '0) && alu.is_load && (alu.rd == rs);
    endfunction

    assign op_a = pick_operand(req.rs1, req.rs1_val, fwd_alu, fwd_mem, fwd_wb);
    assign op_b = pick_operand(req.rs2, req.rs2_val, fwd_alu, fwd_mem, fwd_wb);

    // rs2 is checked for immediate forms too
    assign hazard = load_in_alu(req.rs1, fwd_alu) || load_in_alu(req.rs2, fwd_alu);

endmodule

// File: int_alu.sv
/* Integer ALU: arithmetic, logic, shifts, compares, lui and auipc.
   Loads and stores come in as add with an immediate to form their address */
`timescale 1ns/1ps

module int_alu (
    input  isa_pkg::alu_op_e alu_op,
    input  isa_pkg::xlen_t   op_a,
    input  isa_pkg::xlen_t   op_b,
    input  isa_pkg::xlen_t   imm,
    input  isa_pkg::xlen_t   pc,
    input  logic             use_imm,
    output isa_pkg::xlen_t   result
);
    import isa_pkg::*;

    xlen_t      src_b;
    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign src_b = use_imm ? imm : op_b;

    // RV64 shifts only look at the low six bits
    assign shamt = src_b[5:0];

    assign lt_signed   = $signed(op_a) < $signed(src_b);
    assign lt_unsigned = op_a < src_b;

    always_comb
    begin
        case (alu_op)
            alu_add:
                result = op_a + src_b;
            alu_sub:
                result = op_a - src_b;
            alu_sll:
                result = op_a << shamt;
            alu_slt:
                result = {{(XLEN-1){1'b0}}, lt_signed};
            alu_sltu:
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            alu_xor:
                result = op_a ^ src_b;
            alu_srl:
                result = op_a >> shamt;
            alu_sra:
                result = xlen_t'($signed(op_a) >>> shamt);
            alu_or:
                result = op_a | src_b;
            alu_and:
                result = op_a & src_b;
            alu_lui:
                result = imm;
            alu_auipc:
                result = pc + imm;
            default:
                result = '0;
        endcase
    end

endmodule

// File: branch_unit.sv
/* Branch resolution: evaluates conditional branches, jal and jalr
   into a taken flag, a target address and the link value */
`timescale 1ns/1ps

module branch_unit (
    input  isa_pkg::br_op_e br_op,
    input  isa_pkg::xlen_t  op_a,
    input  isa_pkg::xlen_t  op_b,
    input  isa_pkg::xlen_t  imm,
    input  isa_pkg::xlen_t  pc,
    output logic            taken,
    output isa_pkg::xlen_t  target,
    output isa_pkg::xlen_t  link
);
    import isa_pkg::*;

    xlen_t jalr_sum;

    assign jalr_sum = op_a + imm;
    assign link     = pc + xlen_t'(4);

    always_comb
    begin
        case (br_op)
            br_beq:
                taken = op_a == op_b;
            br_bne:
                taken = op_a != op_b;
            br_blt:
                taken = $signed(op_a) < $signed(op_b);
            br_bge:
                taken = $signed(op_a) >= $signed(op_b);
            br_bltu:
                taken = op_a < op_b;
            br_bgeu:
                taken = op_a >= op_b;
            br_jal, br_jalr:
                taken = 1'b1;
            default:
                taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0, everything else is pc relative
    assign target = (br_op == br_jalr) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

// File: ex_output_reg.sv
/* Execute result register with valid/ready back-pressure and flush.
   Holds its result until memory takes it */
`timescale 1ns/1ps

module ex_output_reg (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              load,
    input  pipe_pkg::ex_rsp_t next_rsp,
    input  logic              out_ready,
    output logic              out_valid,
    output pipe_pkg::ex_rsp_t out_rsp,
    output logic              can_accept
);

    // Room for a new result if empty or the current one leaves this cycle
    assign can_accept = !out_valid || out_ready;

    always_ff @(posedge clk)
    begin
        if (reset || flush)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // Payload only moves on a load
    always_ff @(posedge clk)
    begin
        if (load && !flush)
            out_rsp <= next_rsp;
    end

endmodule

// File: ex_stage.sv
/* RV64I execute stage: forwarding, ALU and branch resolution feeding
   one output register, with a valid/ready handshake on both sides */
`timescale 1ns/1ps

module ex_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  pipe_pkg::ex_req_t  in_req,
    output logic               in_ready,
    input  pipe_pkg::fwd_src_t fwd_alu,
    input  pipe_pkg::fwd_src_t fwd_mem,
    input  pipe_pkg::fwd_src_t fwd_wb,
    input  logic               flush,
    output logic               out_valid,
    output pipe_pkg::ex_rsp_t  out_rsp,
    input  logic               out_ready
);
    import isa_pkg::*;
    import pipe_pkg::*;

    xlen_t   op_a;
    xlen_t   op_b;
    xlen_t   alu_result;
    xlen_t   br_target;
    xlen_t   link;
    logic    hazard;
    logic    br_taken;
    logic    can_accept;
    logic    load;
    logic    is_jump;
    ex_rsp_t next_rsp;

    operand_forward u_operand_forward (
        .req     (in_req),
        .fwd_alu (fwd_alu),
        .fwd_mem (fwd_mem),
        .fwd_wb  (fwd_wb),
        .op_a    (op_a),
        .op_b    (op_b),
        .hazard  (hazard)
    );

    int_alu u_int_alu (
        .alu_op  (in_req.alu_op),
        .op_a    (op_a),
        .op_b    (op_b),
        .imm     (in_req.imm),
        .pc      (in_req.pc),
        .use_imm (in_req.use_imm),
        .result  (alu_result)
    );

    branch_unit u_branch_unit (
        .br_op  (in_req.br_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .imm    (in_req.imm),
        .pc     (in_req.pc),
        .taken  (br_taken),
        .target (br_target),
        .link   (link)
    );

    // Stall on load-use or when the output slot stays full
    assign in_ready = can_accept && !hazard;
    assign load     = in_valid && in_ready;

    assign is_jump = (in_req.br_op == br_jal) || (in_req.br_op == br_jalr);

    always_comb
    begin
        next_rsp.result       = is_jump ? link : alu_result;
        next_rsp.store_data   = op_b;
        next_rsp.rd           = in_req.rd;
        next_rsp.writes_rd    = in_req.writes_rd;
        next_rsp.is_load      = in_req.is_load;
        next_rsp.is_store     = in_req.is_store;
        next_rsp.branch_taken = br_taken;
        next_rsp.target       = br_target;
    end

    ex_output_reg u_ex_output_reg (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .load       (load),
        .next_rsp   (next_rsp),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .can_accept (can_accept)
    );

endmodule

// File: ex_stage_sva.sv
/* Handshake, stall and flush properties for the execute stage */
`timescale 1ns/1ps

module ex_stage_sva (
    input logic              clk,
    input logic              reset,
    input logic              flush,
    input logic              hazard,
    input logic              out_valid,
    input logic              out_ready,
    input pipe_pkg::ex_rsp_t out_rsp
);

    // A blocked result must not change under the consumer
    hold_while_blocked: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_rsp)
    ) else $error("out_rsp changed while out_valid was high and out_ready low");

    flush_clears_valid: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !out_valid
    ) else $error("out_valid was high in the cycle after flush");

    // A stalled instruction never reaches an empty output slot
    stall_on_hazard: assert property (
        @(posedge clk) disable iff (reset)
        hazard && !out_valid |=> !out_valid
    ) else $error("an instruction was accepted during a load-use hazard");

endmodule

// File: tb_ex_stage.sv
/* Testbench for the RV64I execute stage: ALU operations, forwarding,
   load-use stall, branches, back-pressure and flush */
`timescale 1ns/1ps

module tb_ex_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int       MAX_WAIT = 50;
    localparam fwd_src_t NO_FWD   = '0;

    logic        clk;
    logic        reset;
    logic        in_valid;
    ex_req_t     in_req;
    logic        in_ready;
    fwd_src_t    fwd_alu;
    fwd_src_t    fwd_mem;
    fwd_src_t    fwd_wb;
    logic        flush;
    logic        out_valid;
    ex_rsp_t     out_rsp;
    logic        out_ready;
    logic [31:0] lfsr_state;
    ex_rsp_t     rsp;
    int          value_errors;
    int          other_errors;

    ex_stage u_ex_stage (.*);

    bind ex_stage ex_stage_sva u_ex_stage_sva (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .hazard    (hazard),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic xlen_t rand_bits(input int n);
        xlen_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[XLEN-2:0], fb};
        end
        return value;
    endfunction

    function automatic ex_req_t make_req(input alu_op_e alu_op, input br_op_e br_op,
                                         input logic use_imm);
        ex_req_t r;
        r = '0;
        r.pc = rand_bits(64) & ~xlen_t'(3);
        r.rs1_val = rand_bits(64);
        r.rs2_val = rand_bits(64);
        r.imm = rand_bits(64);
        r.rs1 = 5'd1;
        r.rs2 = 5'd2;
        r.rd = 5'd3;
        r.alu_op = alu_op;
        r.br_op = br_op;
        r.use_imm = use_imm;
        r.writes_rd = 1'b1;
        return r;
    endfunction

    function automatic xlen_t alu_expect(input alu_op_e op, input xlen_t a, input xlen_t b,
                                         input xlen_t imm, input xlen_t pc);
        int sh;
        sh = int'(b[5:0]);
        case (op)
            alu_add:   return a + b;
            alu_sub:   return a - b;
            alu_sll:   return a << sh;
            alu_slt:   return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
            alu_sltu:  return (a < b) ? xlen_t'(1) : xlen_t'(0);
            alu_xor:   return a ^ b;
            alu_srl:   return a >> sh;
            alu_sra:   return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
            alu_or:    return a | b;
            alu_and:   return a & b;
            alu_lui:   return imm;
            alu_auipc: return pc + imm;
            default:   return '0;
        endcase
    endfunction

    function automatic logic taken_expect(input br_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            br_beq:          return a == b;
            br_bne:          return a != b;
            br_blt:          return $signed(a) < $signed(b);
            br_bge:          return !($signed(a) < $signed(b));
            br_bltu:         return a < b;
            br_bgeu:         return !(a < b);
            br_jal, br_jalr: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    task automatic expect_eq(input string name, input xlen_t expected, input xlen_t actual);
        assert (actual === expected)
        else
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic expect_bit(input string name, input logic expected, input logic actual);
        expect_eq(name, xlen_t'(expected), xlen_t'(actual));
    endtask

    // Called at a falling edge; returns at the falling edge after acceptance
    task automatic send(input ex_req_t r);
        int waited;
        in_req = r;
        in_valid = 1'b1;
        waited = 0;
        #1;
        while (!in_ready && waited < MAX_WAIT)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!in_ready)
        begin
            $display("Timeout: in_ready stayed low while an instruction was offered");
            other_errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        expect_bit("out_valid one cycle after accept", 1'b1, out_valid);
        rsp = out_rsp;
        expect_eq("rd passed through", xlen_t'(r.rd), xlen_t'(rsp.rd));
        expect_bit("writes_rd passed through", r.writes_rd, rsp.writes_rd);
        expect_bit("is_load passed through", r.is_load, rsp.is_load);
        expect_bit("is_store passed through", r.is_store, rsp.is_store);
    endtask

    initial
    begin
        ex_req_t r;
        xlen_t   fv [3];
        xlen_t   exp;
        xlen_t   exp_target;
        logic    exp_taken;
        ex_rsp_t held;
        lfsr_state = 32'd43;
        value_errors = 0;
        other_errors = 0;
        in_valid = 1'b0;
        in_req = '0;
        fwd_alu = NO_FWD;
        fwd_mem = NO_FWD;
        fwd_wb = NO_FWD;
        flush = 1'b0;
        out_ready = 1'b1;
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        #1;
        expect_bit("in_ready after reset", 1'b1, in_ready);
        expect_bit("out_valid after reset", 1'b0, out_valid);

        for (int i = 0; i < 12; i++)
        begin
            for (int u = 0; u < 2; u++)
            begin
                r = make_req(alu_op_e'(i[3:0]), br_none, u[0]);
                send(r);
                exp = alu_expect(r.alu_op, r.rs1_val, u[0] ? r.imm : r.rs2_val, r.imm, r.pc);
                expect_eq($sformatf("%s use_imm=%0d", r.alu_op.name(), u), exp, rsp.result);
            end
        end

        // x0 ignores a forwarding source that names register 0
        r = make_req(alu_add, br_none, 1'b0);
        r.rs1 = 5'd0;
        fwd_alu = '{rd: 5'd0, writes_rd: 1'b1, is_load: 1'b0, value: rand_bits(64)};
        send(r);
        expect_eq("x0 reads zero", r.rs2_val, rsp.result);

        // Forwarding priority alu, then mem, then wb
        r = make_req(alu_add, br_none, 1'b0);
        for (int s = 0; s < 3; s++)
            fv[s] = rand_bits(64);
        fwd_alu = '{rd: 5'd1, writes_rd: 1'b1, is_load: 1'b0, value: fv[0]};
        fwd_mem = '{rd: 5'd1, writes_rd: 1'b1, is_load: 1'b0, value: fv[1]};
        fwd_wb = '{rd: 5'd1, writes_rd: 1'b1, is_load: 1'b0, value: fv[2]};
        send(r);
        expect_eq("forward from alu", fv[0] + r.rs2_val, rsp.result);
        fwd_alu = NO_FWD;
        send(r);
        expect_eq("forward from mem", fv[1] + r.rs2_val, rsp.result);
        fwd_mem = NO_FWD;
        send(r);
        expect_eq("forward from wb", fv[2] + r.rs2_val, rsp.result);
        fwd_wb = NO_FWD;

        r = make_req(alu_add, br_none, 1'b1);
        r.is_store = 1'b1;
        r.writes_rd = 1'b0;
        fwd_mem = '{rd: 5'd2, writes_rd: 1'b1, is_load: 1'b1, value: fv[0]};
        send(r);
        expect_eq("store data", fv[0], rsp.store_data);
        expect_eq("store address", r.rs1_val + r.imm, rsp.result);
        fwd_mem = NO_FWD;

        r = make_req(alu_add, br_none, 1'b1);
        r.is_load = 1'b1;
        send(r);
        expect_eq("load address", r.rs1_val + r.imm, rsp.result);

        // Load-use stall until the load reaches the memory stage
        @(negedge clk);
        r = make_req(alu_add, br_none, 1'b0);
        fwd_alu = '{rd: 5'd1, writes_rd: 1'b1, is_load: 1'b1, value: '0};
        in_req = r;
        in_valid = 1'b1;
        repeat (3)
        begin
            #1;
            expect_bit("in_ready during load-use", 1'b0, in_ready);
            expect_bit("out_valid during load-use", 1'b0, out_valid);
            @(negedge clk);
        end
        fwd_alu = NO_FWD;
        fwd_mem = '{rd: 5'd1, writes_rd: 1'b1, is_load: 1'b1, value: fv[1]};
        send(r);
        expect_eq("load-use result", fv[1] + r.rs2_val, rsp.result);
        fwd_mem = NO_FWD;

        for (int i = 1; i < 9; i++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                r = make_req(alu_add, br_op_e'(i[3:0]), 1'b0);
                if (k == 0)
                    r.rs2_val = r.rs1_val;
                send(r);
                exp_taken = taken_expect(r.br_op, r.rs1_val, r.rs2_val);
                expect_bit($sformatf("%s taken", r.br_op.name()), exp_taken, rsp.branch_taken);
                if (r.br_op == br_jalr)
                    exp_target = (r.rs1_val + r.imm) & ~xlen_t'(1);
                else
                    exp_target = r.pc + r.imm;
                if (exp_taken)
                    expect_eq($sformatf("%s target", r.br_op.name()), exp_target, rsp.target);
                if (r.br_op == br_jal || r.br_op == br_jalr)
                    exp = r.pc + xlen_t'(4);
                else
                    exp = r.rs1_val + r.rs2_val;
                expect_eq($sformatf("%s result", r.br_op.name()), exp, rsp.result);
            end
        end

        // Back-pressure holds the output and blocks the input
        @(negedge clk);
        out_ready = 1'b0;
        r = make_req(alu_xor, br_none, 1'b0);
        send(r);
        expect_eq("xor under back-pressure", r.rs1_val ^ r.rs2_val, rsp.result);
        held = out_rsp;
        r = make_req(alu_or, br_none, 1'b0);
        in_req = r;
        in_valid = 1'b1;
        repeat (3)
        begin
            #1;
            expect_bit("in_ready under back-pressure", 1'b0, in_ready);
            expect_bit("out_valid under back-pressure", 1'b1, out_valid);
            expect_eq("held result", held.result, out_rsp.result);
            @(negedge clk);
        end
        out_ready = 1'b1;
        send(r);
        expect_eq("or after back-pressure", r.rs1_val | r.rs2_val, rsp.result);

        // Flush drops the instruction offered in the same cycle
        in_req = make_req(alu_sub, br_none, 1'b0);
        in_valid = 1'b1;
        flush = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        flush = 1'b0;
        expect_bit("out_valid after flush", 1'b0, out_valid);
        repeat (2)
        begin
            @(negedge clk);
            expect_bit("flushed instruction absent", 1'b0, out_valid);
        end

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: all.f
isa_pkg.sv
pipe_pkg.sv
operand_forward.sv
int_alu.sv
branch_unit.sv
ex_output_reg.sv
ex_stage.sv
ex_stage_sva.sv
tb_ex_stage.sv

// File: Makefile
# Verilator flow for the RV64I execute stage

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module ex_stage

obj_dir/Vtb_ex_stage: all.f $(wildcard *.sv)
	verilator --binary --timing --assert -f all.f --top-module tb_ex_stage -o Vtb_ex_stage

sim: obj_dir/Vtb_ex_stage
	-./obj_dir/Vtb_ex_stage > sim.log 2>&1
	cat sim.log
	! grep -q "Test failures found" sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
